//--- Bender.yml
package:
  name: cce_to_mc_dram

sources:
  # design, package first
  - files:
      - rtl/mc_dram_pkg.sv
      - rtl/mem_word_if.sv
      - rtl/dram_hash.sv
      - rtl/reorder_fifo.sv
      - rtl/stream_pump_in.sv
      - rtl/stream_pump_out.sv
      - rtl/dram_request_issue.sv
      - rtl/cce_to_mc_dram.sv

  # simulation only
  - target: test
    files:
      - test/cce_to_mc_dram_checker.sv
      - test/tb_cce_to_mc_dram.sv

//--- compile.f
rtl/mc_dram_pkg.sv
rtl/mem_word_if.sv
rtl/dram_hash.sv
rtl/reorder_fifo.sv
rtl/stream_pump_in.sv
rtl/stream_pump_out.sv
rtl/dram_request_issue.sv
rtl/cce_to_mc_dram.sv
test/cce_to_mc_dram_checker.sv
test/tb_cce_to_mc_dram.sv

//--- rtl/cce_to_mc_dram.sv
`timescale 1ns/100ps

module cce_to_mc_dram
  (input  logic                                    clk_i
   , input  logic                                  rst_n_i

   , input  mc_dram_pkg::mem_header_s              mem_fwd_header_i
   , input  mc_dram_pkg::msg_data_t                mem_fwd_data_i
   , input  logic                                  mem_fwd_v_i
   , output logic                                  mem_fwd_ready_and_o

   , output mc_dram_pkg::mem_header_s              mem_rev_header_o
   , output mc_dram_pkg::msg_data_t                mem_rev_data_o
   , output logic                                  mem_rev_v_o
   , input  logic                                  mem_rev_ready_and_i

   , output mc_dram_pkg::mc_packet_s               out_pkt_o
   , output logic                                  out_pkt_v_o
   , input  logic                                  out_pkt_ready_i

   , input  logic                                  ret_v_i
   , input  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0] ret_reg_id_i
   , input  logic [mc_dram_pkg::WORD_WIDTH-1:0]     ret_data_i

   , input  logic [mc_dram_pkg::X_WIDTH-1:0]        global_x_i
   , input  logic [mc_dram_pkg::Y_WIDTH-1:0]        global_y_i
   , input  logic [mc_dram_pkg::POD_WIDTH-1:0]      dram_pod_i
   , input  logic [mc_dram_pkg::ADDR_WIDTH-1:0]     dram_offset_i
   );

  mem_word_if fwd_word ();
  mem_word_if rev_word ();

  stream_pump_in u_stream_pump_in
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.msg_header_i(mem_fwd_header_i)
     ,.msg_data_i(mem_fwd_data_i)
     ,.msg_v_i(mem_fwd_v_i)
     ,.msg_ready_and_o(mem_fwd_ready_and_o)
     ,.fsm(fwd_word.producer)
     );

  dram_request_issue u_dram_request_issue
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.fwd(fwd_word.consumer)
     ,.rev(rev_word.producer)
     ,.out_pkt_o(out_pkt_o)
     ,.out_pkt_v_o(out_pkt_v_o)
     ,.out_pkt_ready_i(out_pkt_ready_i)
     ,.ret_v_i(ret_v_i)
     ,.ret_reg_id_i(ret_reg_id_i)
     ,.ret_data_i(ret_data_i)
     ,.global_x_i(global_x_i)
     ,.global_y_i(global_y_i)
     ,.dram_pod_i(dram_pod_i)
     ,.dram_offset_i(dram_offset_i)
     );

  stream_pump_out u_stream_pump_out
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.fsm(rev_word.consumer)
     ,.msg_header_o(mem_rev_header_o)
     ,.msg_data_o(mem_rev_data_o)
     ,.msg_v_o(mem_rev_v_o)
     ,.msg_ready_and_i(mem_rev_ready_and_i)
     );

endmodule

//--- rtl/dram_hash.sv
`timescale 1ns/100ps

module dram_hash
  (input  logic [mc_dram_pkg::ADDR_WIDTH-1:0]  addr_i
   , input  logic [mc_dram_pkg::ADDR_WIDTH-1:0] offset_i
   , input  logic [mc_dram_pkg::POD_WIDTH-1:0]  pod_i

   , output logic [mc_dram_pkg::X_WIDTH-1:0]    x_cord_o
   , output logic [mc_dram_pkg::Y_WIDTH-1:0]    y_cord_o
   , output logic [mc_dram_pkg::EPA_WIDTH-1:0]  epa_o
   );

  logic [mc_dram_pkg::ADDR_WIDTH-1:0]      eff_addr;
  logic [mc_dram_pkg::WORD_IDX_WIDTH-1:0]  word_idx;
  logic [1:0]                              column;
  logic [mc_dram_pkg::POD_X_WIDTH-1:0]     pod_x;
  logic [mc_dram_pkg::POD_Y_WIDTH-1:0]     pod_y;

  assign eff_addr = addr_i + offset_i;
  assign word_idx = eff_addr[mc_dram_pkg::ADDR_WIDTH-1:2];

  // pod x sits in the low bits
  assign pod_x = pod_i[mc_dram_pkg::POD_X_WIDTH-1:0];
  assign pod_y = pod_i[mc_dram_pkg::POD_WIDTH-1:mc_dram_pkg::POD_X_WIDTH];

  // neighbouring word pairs share a bank column
  assign column = word_idx[2:1];

  assign x_cord_o = mc_dram_pkg::X_WIDTH'(pod_x * mc_dram_pkg::NUM_COLS)
                    + mc_dram_pkg::X_WIDTH'(column);

  // pod_y * 2 plus the top or bottom row select
  assign y_cord_o = mc_dram_pkg::Y_WIDTH'({pod_y, word_idx[3]});

  // drop the bank select bits 3:1 from the word index
  assign epa_o = mc_dram_pkg::EPA_WIDTH'({word_idx[mc_dram_pkg::WORD_IDX_WIDTH-1:4],
                                          word_idx[0]});

endmodule

//--- rtl/dram_request_issue.sv
`timescale 1ns/100ps

module dram_request_issue
  (input  logic                                    clk_i
   , input  logic                                  rst_n_i

   , mem_word_if.consumer                          fwd
   , mem_word_if.producer                          rev

   , output mc_dram_pkg::mc_packet_s               out_pkt_o
   , output logic                                  out_pkt_v_o
   , input  logic                                  out_pkt_ready_i

   , input  logic                                  ret_v_i
   , input  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0] ret_reg_id_i
   , input  logic [mc_dram_pkg::WORD_WIDTH-1:0]     ret_data_i

   , input  logic [mc_dram_pkg::X_WIDTH-1:0]        global_x_i
   , input  logic [mc_dram_pkg::Y_WIDTH-1:0]        global_y_i
   , input  logic [mc_dram_pkg::POD_WIDTH-1:0]      dram_pod_i
   , input  logic [mc_dram_pkg::ADDR_WIDTH-1:0]     dram_offset_i
   );

  logic [mc_dram_pkg::X_WIDTH-1:0]         dram_x_cord;
  logic [mc_dram_pkg::Y_WIDTH-1:0]         dram_y_cord;
  logic [mc_dram_pkg::EPA_WIDTH-1:0]       dram_epa;
  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0]  alloc_id;
  logic                                    alloc_v;
  logic                                    issue;
  logic                                    ret_is_store;
  logic [mc_dram_pkg::WORD_WIDTH-1:0]      ret_data;
  logic [mc_dram_pkg::WORD_WIDTH-1:0]      deq_data;
  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0]  deq_id;
  logic                                    deq_v;
  mc_dram_pkg::mem_header_s                header_mem [mc_dram_pkg::OUTSTANDING_WORDS];
  logic [mc_dram_pkg::OUTSTANDING_WORDS-1:0] last_mem;

  dram_hash u_dram_hash
    (.addr_i(fwd.addr)
     ,.offset_i(dram_offset_i)
     ,.pod_i(dram_pod_i)
     ,.x_cord_o(dram_x_cord)
     ,.y_cord_o(dram_y_cord)
     ,.epa_o(dram_epa)
     );

  reorder_fifo u_reorder_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.alloc_id_o(alloc_id)
     ,.alloc_v_o(alloc_v)
     ,.alloc_yumi_i(issue)
     ,.write_id_i(ret_reg_id_i)
     ,.write_data_i(ret_data)
     ,.write_v_i(ret_v_i)
     ,.deq_data_o(deq_data)
     ,.deq_id_o(deq_id)
     ,.deq_v_o(deq_v)
     ,.deq_yumi_i(rev.yumi)
     );

  // ----------------------------------------
  // outgoing request
  // ----------------------------------------
  // word, free id and network space all in one cycle
  assign issue       = fwd.v & alloc_v & out_pkt_ready_i;
  assign fwd.yumi    = issue;
  assign out_pkt_v_o = issue;

  always_comb
  begin
    out_pkt_o.op     = (fwd.header.msg_type == mc_dram_pkg::e_mem_wr)
                       ? mc_dram_pkg::e_remote_sw : mc_dram_pkg::e_remote_load;
    out_pkt_o.x_cord = dram_x_cord;
    out_pkt_o.y_cord = dram_y_cord;
    out_pkt_o.src_x  = global_x_i;
    out_pkt_o.src_y  = global_y_i;
    out_pkt_o.addr   = dram_epa;
    out_pkt_o.data   = fwd.data;
    out_pkt_o.reg_id = alloc_id;
  end

  // header kept per id until its word comes back
  always_ff @(posedge clk_i)
  begin
    if (issue)
    begin
      header_mem[alloc_id] <= fwd.header;
      last_mem[alloc_id]   <= fwd.last;
    end
  end

  // ----------------------------------------
  // returns, always accepted
  // ----------------------------------------
  // stores carry no data back
  assign ret_is_store = (header_mem[ret_reg_id_i].msg_type == mc_dram_pkg::e_mem_wr);
  assign ret_data     = ret_is_store ? '0 : ret_data_i;

  assign rev.header = header_mem[deq_id];
  assign rev.addr   = header_mem[deq_id].addr;
  assign rev.data   = deq_data;
  assign rev.v      = deq_v;
  assign rev.last   = last_mem[deq_id];

endmodule

//--- rtl/mc_dram_pkg.sv
package mc_dram_pkg;

  // ----------------------------------------
  // widths and depths
  // ----------------------------------------
  localparam int WORD_WIDTH        = 32;
  localparam int ADDR_WIDTH        = 28;
  localparam int MSG_WORDS         = 2;
  localparam int CNT_WIDTH         = 1;
  localparam int SIZE_WIDTH        = 2;
  localparam int TAG_WIDTH         = 8;
  localparam int OUTSTANDING_WORDS = 8;
  localparam int TRANS_ID_WIDTH    = 3;

  // mesh geometry
  localparam int NUM_COLS       = 4;
  localparam int X_WIDTH        = 6;
  localparam int Y_WIDTH        = 6;
  localparam int EPA_WIDTH      = 24;
  localparam int POD_X_WIDTH    = 3;
  localparam int POD_Y_WIDTH    = 3;
  localparam int POD_WIDTH      = POD_X_WIDTH + POD_Y_WIDTH;
  localparam int WORD_IDX_WIDTH = ADDR_WIDTH - 2;

  // ----------------------------------------
  // memory message side
  // ----------------------------------------
  typedef enum logic {
    e_mem_rd,
    e_mem_wr
  } mem_msg_e;

  // size is the word count of the message, 1 or 2
  typedef struct packed {
    mem_msg_e                msg_type;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [SIZE_WIDTH-1:0]   size;
    logic [TAG_WIDTH-1:0]    tag;
  } mem_header_s;

  typedef logic [MSG_WORDS-1:0][WORD_WIDTH-1:0] msg_data_t;

  // ----------------------------------------
  // network side
  // ----------------------------------------
  typedef enum logic {
    e_remote_load,
    e_remote_sw
  } mc_op_e;

  typedef struct packed {
    mc_op_e                    op;
    logic [X_WIDTH-1:0]        x_cord;
    logic [Y_WIDTH-1:0]        y_cord;
    logic [X_WIDTH-1:0]        src_x;
    logic [Y_WIDTH-1:0]        src_y;
    logic [EPA_WIDTH-1:0]      addr;
    logic [WORD_WIDTH-1:0]     data;
    logic [TRANS_ID_WIDTH-1:0] reg_id;
  } mc_packet_s;

endpackage

//--- rtl/mem_word_if.sv
`timescale 1ns/100ps

// one word of a memory message, valid/yumi handshake
interface mem_word_if;

  mc_dram_pkg::mem_header_s             header;
  logic [mc_dram_pkg::ADDR_WIDTH-1:0]   addr;
  logic [mc_dram_pkg::WORD_WIDTH-1:0]   data;
  logic                                 v;
  logic                                 yumi;
  logic                                 last;

  // yumi only while v is high
  modport producer
    (output header
     , output addr
     , output data
     , output v
     , output last
     , input  yumi
     );

  modport consumer
    (input  header
     , input  addr
     , input  data
     , input  v
     , input  last
     , output yumi
     );

endinterface

//--- rtl/reorder_fifo.sv
`timescale 1ns/100ps

module reorder_fifo
  (input  logic                                    clk_i
   , input  logic                                  rst_n_i

   , output logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0] alloc_id_o
   , output logic                                  alloc_v_o
   , input  logic                                  alloc_yumi_i

   , input  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0] write_id_i
   , input  logic [mc_dram_pkg::WORD_WIDTH-1:0]     write_data_i
   , input  logic                                  write_v_i

   , output logic [mc_dram_pkg::WORD_WIDTH-1:0]     deq_data_o
   , output logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0] deq_id_o
   , output logic                                  deq_v_o
   , input  logic                                  deq_yumi_i
   );

  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0]    wr_ptr_r;
  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0]    rd_ptr_r;
  logic [mc_dram_pkg::TRANS_ID_WIDTH:0]      count_r;
  logic [mc_dram_pkg::OUTSTANDING_WORDS-1:0] filled_r;
  logic [mc_dram_pkg::WORD_WIDTH-1:0]        data_mem [mc_dram_pkg::OUTSTANDING_WORDS];

  // ids go out in order and the pointers wrap at the depth
  assign alloc_id_o = wr_ptr_r;
  assign alloc_v_o  = (count_r < mc_dram_pkg::OUTSTANDING_WORDS);

  // head is released only once its return has landed
  assign deq_id_o   = rd_ptr_r;
  assign deq_v_o    = filled_r[rd_ptr_r];
  assign deq_data_o = data_mem[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      filled_r <= '0;
    end
    else
    begin
      if (alloc_yumi_i)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (deq_yumi_i)
        rd_ptr_r <= rd_ptr_r + 1'b1;

      if (alloc_yumi_i & ~deq_yumi_i)
        count_r <= count_r + 1'b1;
      else if (deq_yumi_i & ~alloc_yumi_i)
        count_r <= count_r - 1'b1;

      // a return never targets the head being released
      if (write_v_i)
        filled_r[write_id_i] <= 1'b1;
      if (deq_yumi_i)
        filled_r[rd_ptr_r] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (write_v_i)
      data_mem[write_id_i] <= write_data_i;
  end

endmodule

//--- rtl/stream_pump_in.sv
`timescale 1ns/100ps

module stream_pump_in
  (input  logic                      clk_i
   , input  logic                    rst_n_i

   , input  mc_dram_pkg::mem_header_s msg_header_i
   , input  mc_dram_pkg::msg_data_t   msg_data_i
   , input  logic                    msg_v_i
   , output logic                    msg_ready_and_o

   , mem_word_if.producer            fsm
   );

  logic                                busy_r;
  logic [mc_dram_pkg::CNT_WIDTH-1:0]   cnt_r;
  mc_dram_pkg::mem_header_s            header_r;
  mc_dram_pkg::msg_data_t              data_r;
  logic [mc_dram_pkg::SIZE_WIDTH-1:0]  word_num;
  logic                                accept;

  // idle means a new message can be taken
  assign msg_ready_and_o = ~busy_r;
  assign accept          = msg_v_i & msg_ready_and_o;
  assign word_num        = cnt_r + 1'b1;

  // ----------------------------------------
  // word stepping
  // ----------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (accept)
    begin
      busy_r <= 1'b1;
      cnt_r  <= '0;
    end
    else if (fsm.yumi)
    begin
      if (fsm.last)
        busy_r <= 1'b0;
      cnt_r <= cnt_r + 1'b1;
    end
  end

  // message capture
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      header_r <= msg_header_i;
      data_r   <= msg_data_i;
    end
  end

  // each word sits 4 bytes past the previous one
  assign fsm.header = header_r;
  assign fsm.addr   = header_r.addr + {cnt_r, 2'b00};
  assign fsm.data   = data_r[cnt_r];
  assign fsm.v      = busy_r;
  assign fsm.last   = (word_num == header_r.size);

endmodule

//--- rtl/stream_pump_out.sv
`timescale 1ns/100ps

module stream_pump_out
  (input  logic                       clk_i
   , input  logic                     rst_n_i

   , mem_word_if.consumer             fsm

   , output mc_dram_pkg::mem_header_s msg_header_o
   , output mc_dram_pkg::msg_data_t   msg_data_o
   , output logic                     msg_v_o
   , input  logic                     msg_ready_and_i
   );

  logic                                full_r;
  logic [mc_dram_pkg::CNT_WIDTH-1:0]   cnt_r;
  mc_dram_pkg::mem_header_s            header_r;
  mc_dram_pkg::msg_data_t              data_r;
  logic [mc_dram_pkg::SIZE_WIDTH-1:0]  word_num;
  logic                                final_word;

  // no new words while a finished message waits
  assign fsm.yumi   = fsm.v & ~full_r;
  assign word_num   = cnt_r + 1'b1;
  assign final_word = (word_num == fsm.header.size);

  // ----------------------------------------
  // gather control
  // ----------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      full_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (fsm.yumi)
    begin
      if (final_word)
      begin
        full_r <= 1'b1;
        cnt_r  <= '0;
      end
      else
        cnt_r <= cnt_r + 1'b1;
    end
    else if (msg_v_o & msg_ready_and_i)
      full_r <= 1'b0;
  end

  // word buffer, slot picked by the running count
  always_ff @(posedge clk_i)
  begin
    if (fsm.yumi)
    begin
      data_r[cnt_r] <= fsm.data;
      header_r      <= fsm.header;
    end
  end

  assign msg_header_o = header_r;
  assign msg_data_o   = data_r;
  assign msg_v_o      = full_r;

endmodule

//--- test/cce_to_mc_dram_checker.sv
`timescale 1ns/100ps

module cce_to_mc_dram_checker
  (input  logic                       clk_i
   , input  logic                     rst_n_i

   , input  logic                     mem_fwd_ready_and_o

   , input  mc_dram_pkg::mc_packet_s  out_pkt_o
   , input  logic                     out_pkt_v_o
   , input  logic                     out_pkt_ready_i

   , input  mc_dram_pkg::mem_header_s mem_rev_header_o
   , input  mc_dram_pkg::msg_data_t   mem_rev_data_o
   , input  logic                     mem_rev_v_o
   , input  logic                     mem_rev_ready_and_i
   );

  int fail_count = 0;

  // ----------------------------------------
  // handshake stability
  // ----------------------------------------
  // a word held in the in-pump while the network is not ready keeps every packet field
  pkt_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!mem_fwd_ready_and_o && !out_pkt_ready_i) |=> $stable(out_pkt_o))
  else
  begin
    $error("out_pkt_o changed while the packet was stalled");
    fail_count++;
  end

  // a waiting reverse message keeps valid, header and data
  rev_stable_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_rev_v_o && !mem_rev_ready_and_i)
    |=> (mem_rev_v_o && $stable(mem_rev_header_o) && $stable(mem_rev_data_o)))
  else
  begin
    $error("mem_rev message changed or dropped while stalled");
    fail_count++;
  end

  // nothing valid right after reset
  reset_quiet_a : assert property (@(posedge clk_i)
    !rst_n_i |=> (!mem_rev_v_o && !out_pkt_v_o))
  else
  begin
    $error("valid output high on the cycle after reset");
    fail_count++;
  end

endmodule

bind cce_to_mc_dram cce_to_mc_dram_checker u_checker (.*);

//--- test/mc_dram_cases.txt
// one case per line: op_size_tag_addr_data0_data1_offset_pod_bp (hex)
// op 1 write 0 read, size in words, pod is {pod_y, pod_x}, bp 1 random back-pressure
// write then read back
1_1_11_0000100_cafe0001_00000000_0000000_00_0
0_1_12_0000100_00000000_00000000_0000000_00_0
// two-word read after writes to both words
1_1_13_0000200_a5a50002_00000000_0000000_00_0
1_1_14_0000204_a5a50003_00000000_0000000_00_0
0_2_15_0000200_00000000_00000000_0000000_00_0
1_2_16_0000340_11112222_33334444_0000000_00_0
0_2_17_0000340_00000000_00000000_0000000_00_0
// nonzero offset and pod
1_1_21_0001000_5555aaaa_00000000_0000040_09_0
0_1_22_0001000_00000000_00000000_0000040_09_0
1_2_23_000123c_01234567_89abcdef_0001000_2e_0
0_2_24_000123c_00000000_00000000_0001000_2e_0
1_2_25_0abcdec_deadbeef_feedf00d_0000014_3f_0
0_2_26_0abcdec_00000000_00000000_0000014_3f_0
0_1_27_0abcdf0_00000000_00000000_0000014_3f_0
// many words in flight, returns reordered
1_2_31_0000400_00000401_00000402_0000000_00_0
1_2_32_0000408_00000403_00000404_0000000_00_0
1_2_33_0000410_00000405_00000406_0000000_00_0
0_2_34_0000408_00000000_00000000_0000000_00_0
0_2_35_0000400_00000000_00000000_0000000_00_0
0_2_36_0000410_00000000_00000000_0000000_00_0
// random back-pressure on both ready inputs
1_2_41_0002000_b0b0b0b0_c1c1c1c1_0000100_12_1
0_1_42_0002004_00000000_00000000_0000100_12_1
0_2_43_0002000_00000000_00000000_0000100_12_1
1_1_44_0002008_d2d2d2d2_00000000_0000100_12_1
0_2_45_0002004_00000000_00000000_0000100_12_1
0_1_46_0000100_00000000_00000000_0000000_00_1

//--- test/tb_cce_to_mc_dram.sv
`timescale 1ns/100ps

module tb_cce_to_mc_dram;

  localparam int MAX_CASES       = 64;
  localparam int CYCLES_PER_CASE = 200;
  localparam int POOL_LIMIT      = 4;

  logic                                   clk_i;
  logic                                   rst_n_i;
  mc_dram_pkg::mem_header_s               mem_fwd_header_i;
  mc_dram_pkg::msg_data_t                 mem_fwd_data_i;
  logic                                   mem_fwd_v_i;
  logic                                   mem_fwd_ready_and_o;
  mc_dram_pkg::mem_header_s               mem_rev_header_o;
  mc_dram_pkg::msg_data_t                 mem_rev_data_o;
  logic                                   mem_rev_v_o;
  logic                                   mem_rev_ready_and_i;
  mc_dram_pkg::mc_packet_s                out_pkt_o;
  logic                                   out_pkt_v_o;
  logic                                   out_pkt_ready_i;
  logic                                   ret_v_i;
  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0] ret_reg_id_i;
  logic [mc_dram_pkg::WORD_WIDTH-1:0]     ret_data_i;
  logic [mc_dram_pkg::X_WIDTH-1:0]        global_x_i;
  logic [mc_dram_pkg::Y_WIDTH-1:0]        global_y_i;
  logic [mc_dram_pkg::POD_WIDTH-1:0]      dram_pod_i;
  logic [mc_dram_pkg::ADDR_WIDTH-1:0]     dram_offset_i;

  // op, size, tag, addr, data0, data1, offset, pod, bp
  logic [147:0]                       cases_mem [MAX_CASES];
  int                                 num_cases;
  logic [31:0]                        lfsr_state = 32'h41da_45f8;
  logic                               bp_active;

  // expected results in issue order
  mc_dram_pkg::mc_packet_s            exp_pkt_q [$];
  int                                 exp_pkt_case_q [$];
  mc_dram_pkg::mem_header_s           exp_hdr_q [$];
  mc_dram_pkg::msg_data_t             exp_data_q [$];

  // returns held by the network model
  logic [mc_dram_pkg::TRANS_ID_WIDTH-1:0] pool_id_q [$];
  logic [mc_dram_pkg::WORD_WIDTH-1:0]     pool_data_q [$];

  logic [31:0]                        ref_mem [longint];
  logic [31:0]                        dram_mem [longint];

  int errors = 0;
  int checks = 0;
  int issued = 0;
  int rev_count = 0;
  int cycle_count = 0;
  int case_errors [MAX_CASES];

  cce_to_mc_dram u_cce_to_mc_dram (.*);

  always #2 clk_i = ~clk_i;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val = (val << 1) | lfsr_state[0];
    end
  endtask

  // bank coordinates from the word index of the effective address
  function automatic mc_dram_pkg::mc_packet_s expected_packet(input logic is_write,
      input logic [27:0] byte_addr, input logic [31:0] data, input logic [27:0] offset,
      input logic [5:0] pod, input int id);
    mc_dram_pkg::mc_packet_s p;
    logic [27:0]             eff;
    logic [25:0]             widx;
    eff      = byte_addr + offset;
    widx     = eff >> 2;
    p.op     = is_write ? mc_dram_pkg::e_remote_sw : mc_dram_pkg::e_remote_load;
    p.x_cord = pod[2:0] * 4 + ((widx >> 1) & 3);
    p.y_cord = pod[5:3] * 2 + ((widx >> 3) & 1);
    p.src_x  = global_x_i;
    p.src_y  = global_y_i;
    p.addr   = ((widx >> 4) << 1) | (widx & 1);
    p.data   = data;
    p.reg_id = 3'(id);
    return p;
  endfunction

  task automatic note_error(input int idx);
    errors++;
    if (idx >= 0 && idx < MAX_CASES)
      case_errors[idx]++;
  endtask

  task automatic compare_packet(input int idx, input mc_dram_pkg::mc_packet_s act,
                                input mc_dram_pkg::mc_packet_s exp);
    mc_dram_pkg::mc_packet_s want;
    want = exp;
    // a load's data field carries nothing
    if (want.op == mc_dram_pkg::e_remote_load)
      want.data = act.data;
    checks++;
    if (act !== want)
    begin
      $display("[ERROR] %0d ns: out_pkt_o got %h, expected %h", $time, act, want);
      note_error(idx);
    end
  endtask

  task automatic compare_rev(input int idx,
                             input mc_dram_pkg::mem_header_s act_hdr,
                             input mc_dram_pkg::msg_data_t act_data,
                             input mc_dram_pkg::mem_header_s exp_hdr,
                             input mc_dram_pkg::msg_data_t exp_data);
    checks++;
    if (act_hdr !== exp_hdr)
    begin
      $display("[ERROR] %0d ns: mem_rev_header_o got %h, expected %h",
               $time, act_hdr, exp_hdr);
      note_error(idx);
    end
    for (int w = 0; w < exp_hdr.size; w++)
    begin
      checks++;
      if (act_data[w] !== exp_data[w])
      begin
        $display("[ERROR] %0d ns: mem_rev_data_o[%0d] got %h, expected %h",
                 $time, w, act_data[w], exp_data[w]);
        note_error(idx);
      end
    end
  endtask

  // ----------------------------------------
  // network DRAM model and monitors
  // ----------------------------------------
  task automatic take_packet();
    mc_dram_pkg::mc_packet_s want;
    int                      idx;
    longint                  key;
    logic [31:0]             ret;
    if (exp_pkt_q.size() == 0)
    begin
      $display("%0d ns: a packet left the bridge with no word waiting for it", $time);
      errors++;
    end
    else
    begin
      want = exp_pkt_q.pop_front();
      idx  = exp_pkt_case_q.pop_front();
      compare_packet(idx, out_pkt_o, want);
    end
    key = longint'({out_pkt_o.x_cord, out_pkt_o.y_cord, out_pkt_o.addr});
    // stores echo their data and the bridge clears it on the way back
    if (out_pkt_o.op == mc_dram_pkg::e_remote_sw)
    begin
      dram_mem[key] = out_pkt_o.data;
      ret = out_pkt_o.data;
    end
    else
      ret = dram_mem.exists(key) ? dram_mem[key] : '0;
    pool_id_q.push_back(out_pkt_o.reg_id);
    pool_data_q.push_back(ret);
  endtask

  task automatic take_rev();
    if (exp_hdr_q.size() == 0)
    begin
      $display("%0d ns: a reverse message came with no forward message behind it", $time);
      errors++;
    end
    else
    begin
      compare_rev(rev_count, mem_rev_header_o, mem_rev_data_o,
                  exp_hdr_q.pop_front(), exp_data_q.pop_front());
      if (case_errors[rev_count] == 0)
        $display("case %0d finished: ok", rev_count);
      else
        $display("case %0d finished: %0d mismatches", rev_count, case_errors[rev_count]);
      rev_count++;
    end
  endtask

  always @(posedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (out_pkt_v_o && out_pkt_ready_i)
        take_packet();
      if (mem_rev_v_o && mem_rev_ready_and_i)
        take_rev();
    end
  end

  // ready levels and return release draw all the random bits
  always @(negedge clk_i)
  begin : network
    int bit_val;
    int pick;
    ret_v_i = 1'b0;
    if (rst_n_i)
    begin
      out_pkt_ready_i     = 1'b1;
      mem_rev_ready_and_i = 1'b1;
      if (bp_active)
      begin
        draw_bits(1, bit_val);
        out_pkt_ready_i = bit_val[0];
        draw_bits(1, bit_val);
        mem_rev_ready_and_i = bit_val[0];
      end
      if (pool_id_q.size() != 0)
      begin
        draw_bits(1, bit_val);
        if (bit_val[0] || pool_id_q.size() >= POOL_LIMIT)
        begin
          draw_bits(3, pick);
          pick         = pick % pool_id_q.size();
          ret_v_i      = 1'b1;
          ret_reg_id_i = pool_id_q[pick];
          ret_data_i   = pool_data_q[pick];
          pool_id_q.delete(pick);
          pool_data_q.delete(pick);
        end
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycle_count++;
    if (cycle_count > CYCLES_PER_CASE * (num_cases + 1))
    begin
      $display("timeout after %0d cycles: %0d of %0d reverse messages seen",
               cycle_count, rev_count, num_cases);
      $display("Done: errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // forward message driver
  // ----------------------------------------
  initial
  begin : driver
    logic [147:0]             c;
    logic [3:0]               size_f;
    logic [27:0]              addr_f;
    logic [27:0]              offset_f;
    logic [5:0]               pod_f;
    logic                     is_write;
    mc_dram_pkg::mem_header_s hdr;
    mc_dram_pkg::msg_data_t   words;
    mc_dram_pkg::msg_data_t   rdata;
    longint                   key;

    clk_i               = 1'b0;
    rst_n_i             = 1'b0;
    mem_fwd_header_i    = '0;
    mem_fwd_data_i      = '0;
    mem_fwd_v_i         = 1'b0;
    mem_rev_ready_and_i = 1'b0;
    out_pkt_ready_i     = 1'b0;
    ret_v_i             = 1'b0;
    ret_reg_id_i        = '0;
    ret_data_i          = '0;
    global_x_i          = 6'd5;
    global_y_i          = 6'd9;
    dram_pod_i          = '0;
    dram_offset_i       = '0;
    bp_active           = 1'b0;

    // unread entries stay zero, and a zero size ends the list
    for (int k = 0; k < MAX_CASES; k++)
      cases_mem[k] = '0;
    $readmemh("test/mc_dram_cases.txt", cases_mem);
    num_cases = 0;
    while (num_cases < MAX_CASES && cases_mem[num_cases][143:140] != 4'd0)
      num_cases++;
    if (num_cases == 0)
    begin
      $display("no cases could be read from test/mc_dram_cases.txt");
      errors++;
    end

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int i = 0; i < num_cases; i++)
    begin
      @(negedge clk_i);
      mem_fwd_v_i = 1'b0;
      c        = cases_mem[i];
      is_write = c[144];
      size_f   = c[143:140];
      addr_f   = c[131:104];
      offset_f = c[39:12];
      pod_f    = c[9:4];
      // hashing follows the live inputs, so earlier words drain first
      if (offset_f != dram_offset_i || pod_f != dram_pod_i)
        while (exp_pkt_q.size() != 0)
          @(negedge clk_i);

      hdr.msg_type = is_write ? mc_dram_pkg::e_mem_wr : mc_dram_pkg::e_mem_rd;
      hdr.addr     = addr_f;
      hdr.size     = size_f[1:0];
      hdr.tag      = c[139:132];
      words[0]     = c[103:72];
      words[1]     = c[71:40];
      rdata        = '0;
      for (int w = 0; w < size_f; w++)
      begin
        key = longint'({pod_f, 28'(addr_f + 28'(4 * w) + offset_f) >> 2});
        exp_pkt_q.push_back(expected_packet(is_write, addr_f + 28'(4 * w), words[w],
                                            offset_f, pod_f, issued));
        exp_pkt_case_q.push_back(i);
        issued++;
        if (is_write)
          ref_mem[key] = words[w];
        else
          rdata[w] = ref_mem.exists(key) ? ref_mem[key] : '0;
      end
      exp_hdr_q.push_back(hdr);
      exp_data_q.push_back(rdata);

      bp_active        = c[0];
      dram_offset_i    = offset_f;
      dram_pod_i       = pod_f;
      mem_fwd_header_i = hdr;
      mem_fwd_data_i   = words;
      mem_fwd_v_i      = 1'b1;
      do
        @(posedge clk_i);
      while (!mem_fwd_ready_and_o);
    end
    @(negedge clk_i);
    mem_fwd_v_i = 1'b0;

    // wait for every reverse message
    while (rev_count < num_cases)
      @(negedge clk_i);
    // a few more cycles to catch duplicates
    repeat (10) @(negedge clk_i);
    if (exp_pkt_q.size() != 0 || pool_id_q.size() != 0)
    begin
      $display("%0d words were never sent or never returned",
               exp_pkt_q.size() + pool_id_q.size());
      errors++;
    end
    errors += u_cce_to_mc_dram.u_checker.fail_count;

    $display("%0d cases, %0d checks, %0d errors", num_cases, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
